/* hdl/rot_dims_pkg.sv */
package rot_dims_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Datapath widths
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  localparam int word_width     = 8;                          // One weight
  localparam int cores          = 4;
  localparam int kernel_max     = 3;                          // Kernel width and height limit
  localparam int dma_bits       = 32;
  localparam int line_width     = word_width * cores * kernel_max;
  localparam int words_per_line = line_width / dma_bits;
  localparam int pack_width     = line_width - dma_bits;      // Words held before a line write

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Frame limits
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  localparam int cin_max    = 64;
  localparam int blocks_max = 16;

  localparam int bits_k      = $clog2(kernel_max);
  localparam int bits_cin    = $clog2(cin_max);
  localparam int bits_blocks = $clog2(blocks_max);
  localparam int bits_phase  = $clog2(words_per_line);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Line memory and output queue
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  localparam int ram_lines   = kernel_max * cin_max;         // Per bank
  localparam int ram_latency = 2;
  localparam int bits_addr   = $clog2(ram_lines);
  localparam int fifo_depth  = 4;
  localparam int bits_fifo   = $clog2(fifo_depth);
  localparam int bits_count  = $clog2(fifo_depth + 1);

endpackage

/* hdl/rot_types_pkg.sv */
package rot_types_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Frame header and stream sideband
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // Sits in the low bits of the first input word
  typedef struct packed {
    logic [rot_dims_pkg::bits_k-1:0]      k_1;       // 0 is 1x1, 2 is 3x3
    logic [rot_dims_pkg::bits_cin-1:0]    cin_1;
    logic [rot_dims_pkg::bits_blocks-1:0] blocks_1;
  } rot_header_t;

  typedef struct packed {
    logic                            is_config;
    logic [rot_dims_pkg::bits_k-1:0] k_1;
  } rot_tuser_t;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Bank ownership
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  typedef struct packed {
    logic                               full;      // Reader owns the bank
    rot_header_t                        header;
    logic [rot_dims_pkg::bits_addr-1:0] lines_1;
  } bank_desc_t;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Control states
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  typedef enum logic [1:0] {
    wr_header,
    wr_data,
    wr_drop                                          // Discard up to tlast
  } writer_state_e;

  typedef enum logic [1:0] {
    rd_idle,
    rd_config,
    rd_lines,
    rd_release
  } reader_state_e;

endpackage

/* hdl/weight_writer.sv */
`timescale 1ns/10ps

module weight_writer (
  input  logic                                  aclk,
  input  logic                                  rst_n,
  input  logic [rot_dims_pkg::dma_bits-1:0]     s_tdata,
  input  logic                                  s_tvalid,
  input  logic                                  s_tlast,
  output logic                                  s_tready,
  output logic                                  wr_en,
  output logic                                  wr_bank,
  output logic [rot_dims_pkg::bits_addr-1:0]    wr_addr,
  output logic [rot_dims_pkg::line_width-1:0]   wr_line,
  output rot_types_pkg::bank_desc_t [1:0]       bank_desc,
  input  logic [1:0]                            bank_release,
  output logic                                  len_error
);

  rot_types_pkg::writer_state_e         state;
  rot_types_pkg::rot_header_t           hdr;
  rot_types_pkg::rot_header_t           in_hdr;
  logic [rot_dims_pkg::bits_addr-1:0]   lines_1;
  logic [rot_dims_pkg::bits_addr-1:0]   hdr_lines_1;
  logic [rot_dims_pkg::bits_addr-1:0]   cin_ext;
  logic [rot_dims_pkg::bits_addr-1:0]   line_addr;
  logic [rot_dims_pkg::bits_phase-1:0]  phase;
  logic [rot_dims_pkg::pack_width-1:0]  pack;
  logic                                 wr_sel;
  logic                                 beat;
  logic                                 legal_k;
  logic                                 line_done;
  logic                                 last_word;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Header decode
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  assign in_hdr  = s_tdata[$bits(rot_types_pkg::rot_header_t)-1:0];
  assign cin_ext = {{(rot_dims_pkg::bits_addr-rot_dims_pkg::bits_cin){1'b0}}, in_hdr.cin_1};
  assign legal_k = (in_hdr.k_1 == '0) || (in_hdr.k_1 == rot_dims_pkg::kernel_max - 1);

  // 3x3 keeps three lines per channel
  assign hdr_lines_1 = (in_hdr.k_1 == '0) ? cin_ext : (cin_ext << 1) + cin_ext + 8'd2;

  always_comb begin
    case (state)
      rot_types_pkg::wr_header: s_tready = !bank_desc[wr_sel].full;  // Wait for free bank
      default:                  s_tready = 1'b1;
    endcase
  end

  assign beat      = s_tvalid && s_tready;
  assign line_done = (phase == rot_dims_pkg::words_per_line - 1);
  assign last_word = line_done && (line_addr == lines_1);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Line packing and RAM write
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  assign wr_en   = beat && (state == rot_types_pkg::wr_data) && line_done;
  assign wr_bank = wr_sel;
  assign wr_addr = line_addr;
  assign wr_line = {s_tdata, pack};                   // Oldest word lands lowest

  always_ff @(posedge aclk) begin
    if (beat && state == rot_types_pkg::wr_header) begin
      hdr     <= in_hdr;
      lines_1 <= hdr_lines_1;
    end
    if (beat && state == rot_types_pkg::wr_data) begin
      pack <= {s_tdata, pack[rot_dims_pkg::pack_width-1:rot_dims_pkg::dma_bits]};
    end
  end

  always_ff @(posedge aclk) begin
    if (!rst_n) begin
      state     <= rot_types_pkg::wr_header;
      wr_sel    <= 1'b0;
      line_addr <= '0;
      phase     <= '0;
      len_error <= 1'b0;
      for (int b = 0; b < 2; b++) begin
        bank_desc[b].full <= 1'b0;
      end
    end else begin
      len_error <= 1'b0;
      for (int b = 0; b < 2; b++) begin
        if (bank_release[b]) bank_desc[b].full <= 1'b0;  // Reader is done with it
      end
      case (state)
        rot_types_pkg::wr_header: begin
          if (beat) begin
            line_addr <= '0;
            phase     <= '0;
            if (s_tlast) begin
              len_error <= 1'b1;                      // Header only
            end else if (!legal_k) begin
              state <= rot_types_pkg::wr_drop;
            end else begin
              state <= rot_types_pkg::wr_data;
            end
          end
        end
        rot_types_pkg::wr_data: begin
          if (beat) begin
            phase <= line_done ? '0 : phase + 1'b1;
            if (line_done) line_addr <= line_addr + 1'b1;
            if (s_tlast) begin
              state <= rot_types_pkg::wr_header;
              if (last_word) begin
                bank_desc[wr_sel].full    <= 1'b1;
                bank_desc[wr_sel].header  <= hdr;
                bank_desc[wr_sel].lines_1 <= lines_1;
                wr_sel                    <= ~wr_sel;
              end else begin
                len_error <= 1'b1;                    // Short frame
              end
            end else if (last_word) begin
              state <= rot_types_pkg::wr_drop;        // Long frame
            end
          end
        end
        rot_types_pkg::wr_drop: begin
          if (beat && s_tlast) begin
            len_error <= 1'b1;
            state     <= rot_types_pkg::wr_header;
          end
        end
        default: state <= rot_types_pkg::wr_header;
      endcase
    end
  end

endmodule

/* hdl/weight_bank_ram.sv */
`timescale 1ns/10ps

module weight_bank_ram (
  input  logic                                aclk,
  input  logic                                wr_en,
  input  logic                                wr_bank,
  input  logic [rot_dims_pkg::bits_addr-1:0]  wr_addr,
  input  logic [rot_dims_pkg::line_width-1:0] wr_line,
  input  logic                                rd_en,
  input  logic                                rd_bank,
  input  logic [rot_dims_pkg::bits_addr-1:0]  rd_addr,
  output logic [rot_dims_pkg::line_width-1:0] rd_line
);

  logic [rot_dims_pkg::line_width-1:0] mem [2][rot_dims_pkg::ram_lines];
  logic                                rd_bank_q;
  logic [rot_dims_pkg::bits_addr-1:0]  rd_addr_q;

  always_ff @(posedge aclk) begin
    if (wr_en) mem[wr_bank][wr_addr] <= wr_line;
  end

  // Address stage then output stage
  always_ff @(posedge aclk) begin
    if (rd_en) begin
      rd_bank_q <= rd_bank;
      rd_addr_q <= rd_addr;
    end
    rd_line <= mem[rd_bank_q][rd_addr_q];
  end

endmodule

/* hdl/weight_reader.sv */
`timescale 1ns/10ps

module weight_reader (
  input  logic                                aclk,
  input  logic                                rst_n,
  input  rot_types_pkg::bank_desc_t [1:0]     bank_desc,
  output logic                                rd_en,
  output logic                                rd_bank,
  output logic [rot_dims_pkg::bits_addr-1:0]  rd_addr,
  input  logic [rot_dims_pkg::line_width-1:0] rd_line,
  output logic [1:0]                          bank_release,
  output logic [rot_dims_pkg::line_width-1:0] m_tdata,
  output rot_types_pkg::rot_tuser_t           m_tuser,
  output logic                                m_tvalid,
  output logic                                m_tlast,
  input  logic                                m_tready
);

  typedef struct packed {
    logic                       valid;
    rot_types_pkg::rot_tuser_t  tuser;
    logic                       last;
    rot_types_pkg::rot_header_t hdr;
  } tag_t;

  typedef struct packed {
    logic [rot_dims_pkg::line_width-1:0] data;
    rot_types_pkg::rot_tuser_t           tuser;
    logic                                last;
  } entry_t;

  rot_types_pkg::reader_state_e          state;
  rot_types_pkg::bank_desc_t             desc;
  logic                                  rd_sel;
  logic [rot_dims_pkg::bits_blocks-1:0]  block_cnt;
  logic [rot_dims_pkg::bits_addr-1:0]    line_cnt;
  tag_t                                  tag_in;
  tag_t                                  tag_out;
  tag_t [rot_dims_pkg::ram_latency-1:0]  tag_q;
  entry_t                                queue [rot_dims_pkg::fifo_depth];
  entry_t                                push_entry;
  logic [rot_dims_pkg::bits_fifo-1:0]    wptr;
  logic [rot_dims_pkg::bits_fifo-1:0]    rptr;
  logic [rot_dims_pkg::bits_count-1:0]   q_count;
  logic [rot_dims_pkg::bits_count-1:0]   inflight;
  logic                                  issue_ok;
  logic                                  push;
  logic                                  pop;

  assign desc = bank_desc[rd_sel];

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Credit check
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_comb begin
    inflight = '0;
    for (int i = 0; i < rot_dims_pkg::ram_latency; i++) begin
      inflight = inflight + tag_q[i].valid;
    end
  end

  // Keep filling an empty queue even when the sink is stalled
  assign issue_ok = (q_count + inflight < rot_dims_pkg::fifo_depth) &&
                    (m_tready || q_count == '0);

  always_comb begin
    tag_in           = '0;
    tag_in.hdr       = desc.header;
    tag_in.tuser.k_1 = desc.header.k_1;
    rd_en            = 1'b0;
    case (state)
      rot_types_pkg::rd_config: begin
        tag_in.valid           = issue_ok;
        tag_in.tuser.is_config = 1'b1;
      end
      rot_types_pkg::rd_lines: begin
        tag_in.valid = issue_ok;
        tag_in.last  = (line_cnt == desc.lines_1);
        rd_en        = issue_ok;
      end
      default: ;
    endcase
  end

  assign rd_bank      = rd_sel;
  assign rd_addr      = line_cnt;
  assign bank_release = (state == rot_types_pkg::rd_release) ? (2'b01 << rd_sel) : 2'b00;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Replay FSM
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge aclk) begin
    if (!rst_n) begin
      state     <= rot_types_pkg::rd_idle;
      rd_sel    <= 1'b0;
      block_cnt <= '0;
      line_cnt  <= '0;
      tag_q     <= '0;
    end else begin
      tag_q <= {tag_q[rot_dims_pkg::ram_latency-2:0], tag_in};  // Tracks RAM latency
      case (state)
        rot_types_pkg::rd_idle: begin
          if (desc.full) begin
            block_cnt <= '0;
            state     <= rot_types_pkg::rd_config;
          end
        end
        rot_types_pkg::rd_config: begin
          if (issue_ok) begin
            line_cnt <= '0;
            state    <= rot_types_pkg::rd_lines;
          end
        end
        rot_types_pkg::rd_lines: begin
          if (issue_ok) begin
            if (line_cnt == desc.lines_1) begin
              if (block_cnt == desc.header.blocks_1) begin
                state <= rot_types_pkg::rd_release;
              end else begin
                block_cnt <= block_cnt + 1'b1;
                state     <= rot_types_pkg::rd_config;
              end
            end else begin
              line_cnt <= line_cnt + 1'b1;
            end
          end
        end
        rot_types_pkg::rd_release: begin
          rd_sel <= ~rd_sel;                          // Banks drain in turn
          state  <= rot_types_pkg::rd_idle;
        end
        default: state <= rot_types_pkg::rd_idle;
      endcase
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Output queue
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  assign tag_out = tag_q[rot_dims_pkg::ram_latency-1];
  assign push    = tag_out.valid;
  assign pop     = m_tvalid && m_tready;

  always_comb begin
    push_entry.tuser = tag_out.tuser;
    push_entry.last  = tag_out.last;
    if (tag_out.tuser.is_config) begin
      push_entry.data = {{(rot_dims_pkg::line_width-$bits(rot_types_pkg::rot_header_t)){1'b0}},
                         tag_out.hdr};
    end else begin
      push_entry.data = rd_line;
    end
  end

  always_ff @(posedge aclk) begin
    if (push) queue[wptr] <= push_entry;
  end

  always_ff @(posedge aclk) begin
    if (!rst_n) begin
      wptr    <= '0;
      rptr    <= '0;
      q_count <= '0;
    end else begin
      if (push) wptr <= wptr + 1'b1;
      if (pop) rptr <= rptr + 1'b1;
      case ({push, pop})
        2'b10:   q_count <= q_count + 1'b1;
        2'b01:   q_count <= q_count - 1'b1;
        default: ;
      endcase
    end
  end

  assign m_tvalid = (q_count != '0);
  assign m_tdata  = queue[rptr].data;
  assign m_tuser  = queue[rptr].tuser;
  assign m_tlast  = queue[rptr].last;

endmodule

/* hdl/axis_weight_rotator.sv */
`timescale 1ns/10ps

module axis_weight_rotator (
  input  logic                                aclk,
  input  logic                                rst_n,
  input  logic [rot_dims_pkg::dma_bits-1:0]   s_tdata,
  input  logic                                s_tvalid,
  input  logic                                s_tlast,
  output logic                                s_tready,
  output logic [rot_dims_pkg::line_width-1:0] m_tdata,
  output rot_types_pkg::rot_tuser_t           m_tuser,
  output logic                                m_tvalid,
  output logic                                m_tlast,
  input  logic                                m_tready,
  output logic                                len_error
);

  // Write side
  logic                                wr_en;
  logic                                wr_bank;
  logic [rot_dims_pkg::bits_addr-1:0]  wr_addr;
  logic [rot_dims_pkg::line_width-1:0] wr_line;

  // Read side
  logic                                rd_en;
  logic                                rd_bank;
  logic [rot_dims_pkg::bits_addr-1:0]  rd_addr;
  logic [rot_dims_pkg::line_width-1:0] rd_line;

  // Bank hand-off
  rot_types_pkg::bank_desc_t [1:0]     bank_desc;
  logic [1:0]                          bank_release;

  weight_writer u_weight_writer (
    .aclk         (aclk),
    .rst_n        (rst_n),
    .s_tdata      (s_tdata),
    .s_tvalid     (s_tvalid),
    .s_tlast      (s_tlast),
    .s_tready     (s_tready),
    .wr_en        (wr_en),
    .wr_bank      (wr_bank),
    .wr_addr      (wr_addr),
    .wr_line      (wr_line),
    .bank_desc    (bank_desc),
    .bank_release (bank_release),
    .len_error    (len_error)
  );

  weight_bank_ram u_weight_bank_ram (
    .aclk    (aclk),
    .wr_en   (wr_en),
    .wr_bank (wr_bank),
    .wr_addr (wr_addr),
    .wr_line (wr_line),
    .rd_en   (rd_en),
    .rd_bank (rd_bank),
    .rd_addr (rd_addr),
    .rd_line (rd_line)
  );

  weight_reader u_weight_reader (
    .aclk         (aclk),
    .rst_n        (rst_n),
    .bank_desc    (bank_desc),
    .rd_en        (rd_en),
    .rd_bank      (rd_bank),
    .rd_addr      (rd_addr),
    .rd_line      (rd_line),
    .bank_release (bank_release),
    .m_tdata      (m_tdata),
    .m_tuser      (m_tuser),
    .m_tvalid     (m_tvalid),
    .m_tlast      (m_tlast),
    .m_tready     (m_tready)
  );

endmodule

/* testbench/rotator_assertions.sv */
`timescale 1ns/10ps

module rotator_assertions (
  input logic                                aclk,
  input logic                                rst_n,
  input logic [rot_dims_pkg::dma_bits-1:0]   s_tdata,
  input logic                                s_tvalid,
  input logic                                s_tlast,
  input logic                                s_tready,
  input logic [rot_dims_pkg::line_width-1:0] m_tdata,
  input rot_types_pkg::rot_tuser_t           m_tuser,
  input logic                                m_tvalid,
  input logic                                m_tlast,
  input logic                                m_tready
);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Input stream
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  s_valid_held: assert property (@(posedge aclk) disable iff (!rst_n)
    s_tvalid && !s_tready |=> s_tvalid)
    else $error("s_tvalid fell before its beat transferred");

  s_data_stable: assert property (@(posedge aclk) disable iff (!rst_n)
    s_tvalid && !s_tready |=> $stable(s_tdata) && $stable(s_tlast))
    else $error("s_tdata or s_tlast changed while stalled");

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Output stream
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  m_valid_held: assert property (@(posedge aclk) disable iff (!rst_n)
    m_tvalid && !m_tready |=> m_tvalid)
    else $error("m_tvalid fell before its beat transferred");

  m_data_stable: assert property (@(posedge aclk) disable iff (!rst_n)
    m_tvalid && !m_tready |=> $stable(m_tdata) && $stable(m_tuser) && $stable(m_tlast))
    else $error("m_tdata, m_tuser or m_tlast changed while stalled");

  m_idle_after_reset: assert property (@(posedge aclk) !rst_n |=> !m_tvalid)
    else $error("m_tvalid high right after reset");

endmodule

bind axis_weight_rotator rotator_assertions u_rotator_assertions (
  .aclk     (aclk),
  .rst_n    (rst_n),
  .s_tdata  (s_tdata),
  .s_tvalid (s_tvalid),
  .s_tlast  (s_tlast),
  .s_tready (s_tready),
  .m_tdata  (m_tdata),
  .m_tuser  (m_tuser),
  .m_tvalid (m_tvalid),
  .m_tlast  (m_tlast),
  .m_tready (m_tready)
);

/* testbench/tb_weight_rotator.sv */
`timescale 1ns/10ps

module tb_weight_rotator;

  typedef struct packed {
    logic [rot_dims_pkg::line_width-1:0] data;
    rot_types_pkg::rot_tuser_t           tuser;
    logic                                last;
  } beat_t;

  typedef beat_t                             beat_q_t[$];
  typedef logic [rot_dims_pkg::dma_bits-1:0] word_q_t[$];
  typedef enum {frame_ok, frame_short, frame_long} frame_kind_e;

  localparam int send_timeout  = 5000;              // Cycles per input beat
  localparam int drain_timeout = 40000;

  logic                                aclk;
  logic                                rst_n;
  logic [rot_dims_pkg::dma_bits-1:0]   s_tdata;
  logic                                s_tvalid;
  logic                                s_tlast;
  logic                                s_tready;
  logic [rot_dims_pkg::line_width-1:0] m_tdata;
  rot_types_pkg::rot_tuser_t           m_tuser;
  logic                                m_tvalid;
  logic                                m_tlast;
  logic                                m_tready;
  logic                                len_error;

  beat_q_t exp_q;
  beat_t   head_beat;
  int      mismatch_count  = 0;
  int      other_count     = 0;
  int      beats_checked   = 0;
  int      good_frames     = 0;
  int      exp_len_errors  = 0;
  int      seen_len_errors = 0;
  int      in_gap_pct      = 0;
  int      out_stall_pct   = 0;

  axis_weight_rotator u_axis_weight_rotator (
    .aclk      (aclk),
    .rst_n     (rst_n),
    .s_tdata   (s_tdata),
    .s_tvalid  (s_tvalid),
    .s_tlast   (s_tlast),
    .s_tready  (s_tready),
    .m_tdata   (m_tdata),
    .m_tuser   (m_tuser),
    .m_tvalid  (m_tvalid),
    .m_tlast   (m_tlast),
    .m_tready  (m_tready),
    .len_error (len_error)
  );

  initial begin
    aclk = 1'b0;
    forever #10 aclk = ~aclk;
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Reference model and checks
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  function automatic beat_q_t expected_beats(input rot_types_pkg::rot_header_t hdr,
                                             input word_q_t words);
    beat_q_t beats;
    beat_t   b;
    int      lines;
    lines = (int'(hdr.k_1) + 1) * (int'(hdr.cin_1) + 1);
    for (int blk = 0; blk <= int'(hdr.blocks_1); blk++) begin
      b                = '0;
      b.data[$bits(rot_types_pkg::rot_header_t)-1:0] = hdr;
      b.tuser.is_config = 1'b1;
      b.tuser.k_1       = hdr.k_1;
      beats.push_back(b);
      for (int j = 0; j < lines; j++) begin
        b.data            = {words[3*j+2], words[3*j+1], words[3*j]};  // First word lowest
        b.tuser.is_config = 1'b0;
        b.last            = (j == lines - 1);
        beats.push_back(b);
      end
    end
    return beats;
  endfunction

  task automatic check_value(input string name, input logic [rot_dims_pkg::line_width-1:0] got,
                             input logic [rot_dims_pkg::line_width-1:0] exp);
    if (got !== exp) begin
      mismatch_count++;
      $display("[FAIL] %0t ns %s: got %0h, expected %0h", $time, name, got, exp);
    end
  endtask

  task automatic finish_run();
    $display("Checked %0d output beats: %0d mismatches, %0d other errors",
             beats_checked, mismatch_count, other_count);
    if (mismatch_count == 0 && other_count == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  endtask

  // Handshakes are judged mid-cycle where both sides are settled
  always @(negedge aclk) begin
    if (rst_n) begin
      if (len_error) seen_len_errors++;
      if (good_frames == 0) check_value("m_tvalid", m_tvalid, 1'b0);  // Nothing stored yet
      if (m_tvalid && m_tready) begin
        if (exp_q.size() == 0) begin
          other_count++;
          $display("Error at %0t ns: output beat arrived while none was expected", $time);
        end else begin
          head_beat = exp_q.pop_front();
          check_value("m_tdata", m_tdata, head_beat.data);
          check_value("m_tuser", m_tuser, head_beat.tuser);
          check_value("m_tlast", m_tlast, head_beat.last);
          beats_checked++;
        end
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Stimulus
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  initial begin
    m_tready = 1'b1;
    forever begin
      @(posedge aclk);
      #1;
      m_tready = ($urandom_range(99, 0) >= out_stall_pct);
    end
  end

  // Entered and left 1 ns after a rising edge
  task automatic send_beat(input logic [rot_dims_pkg::dma_bits-1:0] data, input logic last);
    int waited;
    int gap;
    gap = ($urandom_range(99, 0) < in_gap_pct) ? $urandom_range(3, 1) : 0;
    if (gap > 0) begin
      s_tvalid = 1'b0;
      repeat (gap) @(posedge aclk);
      #1;
    end
    s_tvalid = 1'b1;
    s_tdata  = data;
    s_tlast  = last;
    waited   = 0;
    @(negedge aclk);
    while (!s_tready) begin
      waited++;
      if (waited > send_timeout) begin
        other_count++;
        $display("Timeout at %0t ns: input stream never became ready", $time);
        finish_run();
      end
      @(negedge aclk);
    end
    @(posedge aclk);
    #1;
  endtask

  task automatic run_frame(input int k_1, input int cin_1, input int blocks_1,
                           input frame_kind_e kind);
    rot_types_pkg::rot_header_t hdr;
    word_q_t                    words;
    beat_q_t                    beats;
    int                         n_words;
    hdr.k_1      = k_1;
    hdr.cin_1    = cin_1;
    hdr.blocks_1 = blocks_1;
    n_words      = (k_1 + 1) * (cin_1 + 1) * 3;
    for (int i = 0; i < n_words; i++) begin
      words.push_back($urandom);
    end
    if (kind == frame_ok) begin
      beats = expected_beats(hdr, words);
      foreach (beats[i]) exp_q.push_back(beats[i]);
    end else begin
      exp_len_errors++;
    end
    if (kind == frame_short) void'(words.pop_back());
    if (kind == frame_long) words.push_back($urandom);
    send_beat({{(rot_dims_pkg::dma_bits - $bits(hdr)){1'b0}}, hdr}, 1'b0);
    foreach (words[i]) send_beat(words[i], i == words.size() - 1);
    s_tvalid = 1'b0;
    s_tlast  = 1'b0;
    if (kind == frame_ok) begin
      good_frames++;
    end else begin
      repeat (2) @(negedge aclk);
      check_value("len_error pulses", seen_len_errors, exp_len_errors);  // One per bad frame
      @(posedge aclk);
      #1;
    end
  endtask

  task automatic drain();
    int waited;
    waited = 0;
    while (exp_q.size() != 0) begin
      @(negedge aclk);
      waited++;
      if (waited > drain_timeout) begin
        other_count++;
        $display("Timeout at %0t ns: %0d expected output beats never arrived",
                 $time, exp_q.size());
        finish_run();
      end
    end
    @(posedge aclk);
    #1;
  endtask

  initial begin
    void'($urandom(340));
    rst_n    = 1'b0;
    s_tvalid = 1'b0;
    s_tlast  = 1'b0;
    s_tdata  = '0;
    repeat (3) @(posedge aclk);
    #1;
    rst_n = 1'b1;

    run_frame(2, 3, 1, frame_ok);                   // 3x3, four channels, two blocks
    drain();
    run_frame(0, 5, 2, frame_ok);                   // 1x1
    drain();

    in_gap_pct    = 30;
    out_stall_pct = 50;
    repeat (5) begin
      run_frame(($urandom_range(1, 0) == 1) ? 2 : 0, $urandom_range(7, 0),
                $urandom_range(3, 0), frame_ok);
    end
    drain();
    in_gap_pct    = 0;
    out_stall_pct = 0;

    run_frame(2, 7, 2, frame_ok);                   // Back to back across both banks
    run_frame(0, 15, 1, frame_ok);
    run_frame(2, 3, 3, frame_ok);
    drain();

    run_frame(2, 2, 1, frame_short);
    run_frame(0, 9, 0, frame_long);
    run_frame(2, 1, 2, frame_ok);
    drain();

    repeat (50) @(negedge aclk);                    // Catch stray beats
    check_value("len_error pulses", seen_len_errors, exp_len_errors);
    finish_run();
  end

endmodule

/* sources.f */
hdl/rot_dims_pkg.sv
hdl/rot_types_pkg.sv
hdl/weight_writer.sv
hdl/weight_bank_ram.sv
hdl/weight_reader.sv
hdl/axis_weight_rotator.sv
testbench/rotator_assertions.sv
testbench/tb_weight_rotator.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_weight_rotator
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "SIMULATION FAILED" $(LOG); then \
	  echo "Failure reported in $(LOG)"; exit 1; \
	fi
	@if ! grep -q "SIMULATION PASSED" $(LOG); then \
	  echo "Run ended without a verdict in $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
